/* sim.f */
verilog/benes_pkg.sv
verilog/vector_fifo.sv
verilog/benes_permuter.sv
verilog/axi_burst_slave.sv
verilog/axi_benes_top.sv
dv/axi_benes_assert.sv
dv/tb_axi_benes.sv

/* Bender.yml */
package:
  name: axi_benes

sources:
  - files:
      - verilog/benes_pkg.sv
      - verilog/vector_fifo.sv
      - verilog/benes_permuter.sv
      - verilog/axi_burst_slave.sv
      - verilog/axi_benes_top.sv
  - target: test
    files:
      - dv/axi_benes_assert.sv
      - dv/tb_axi_benes.sv

/* dv/tb_axi_benes.sv */
`default_nettype none

module tb_axi_benes
  import benes_pkg::*;
();

  localparam int fifo_depth = 4;
  localparam int id_w       = 2;
  localparam int addr_w     = 8;
  localparam int max_cycles = 4000;

  logic              S_AXI_ACLK;
  logic              S_AXI_ARESETN;
  logic [id_w-1:0]   awid;
  logic [addr_w-1:0] awaddr;
  logic [7:0]        awlen;
  logic [1:0]        awburst;
  logic [2:0]        awsize;
  logic              awvalid;
  logic              awready;
  vec_t              wdata;
  logic              wlast;
  logic              wvalid;
  logic              wready;
  logic [id_w-1:0]   bid;
  axi_resp_e         bresp;
  logic              bvalid;
  logic              bready;
  logic [id_w-1:0]   arid;
  logic [addr_w-1:0] araddr;
  logic [7:0]        arlen;
  logic [1:0]        arburst;
  logic [2:0]        arsize;
  logic              arvalid;
  logic              arready;
  logic [id_w-1:0]   rid;
  vec_t              rdata;
  axi_resp_e         rresp;
  logic              rlast;
  logic              rvalid;
  logic              rready;

  integer      seed;
  int          errors;
  int          checks;
  int unsigned cycles;
  int unsigned assert_fails;
  benes_cfg_t  cur_cfg;
  vec_t        wr_buf [16];
  vec_t        exp_q [$];

  axi_benes_top #(
    .fifo_depth (fifo_depth),
    .id_w       (id_w),
    .addr_w     (addr_w)
  ) i_dut (.*);

  always #2 S_AXI_ACLK = ~S_AXI_ACLK;

  // Run limit
  always @(posedge S_AXI_ACLK) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("tests failed");
      $finish;
    end
  end

  task automatic step();
    @(posedge S_AXI_ACLK);
    #1;
  endtask

  task automatic check_vec(input string name, input vec_t got, input vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input logic [id_w-1:0] got,
                          input logic [id_w-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // Bit s*4+k swaps lanes 2k and 2k+1 in switch column s
  function automatic vec_t switch_col(input vec_t v, input benes_cfg_t c, input int s);
    vec_t  r;
    lane_t t;
    r = v;
    for (int k = 0; k < lanes / 2; k++) begin
      if (c[s*4+k]) begin
        t        = r[2*k];
        r[2*k]   = r[2*k+1];
        r[2*k+1] = t;
      end
    end
    return r;
  endfunction

  // Each lane moves to its index with the low bits rotated
  // A left rotation is a shuffle and a right rotation its inverse
  function automatic vec_t rotate_lanes(input vec_t v, input int bits, input bit left);
    vec_t r;
    int   lo;
    int   dst;
    int   mask;
    mask = (1 << bits) - 1;
    for (int p = 0; p < lanes; p++) begin
      lo = p & mask;
      if (left) begin
        dst = (p - lo) + (((lo << 1) | (lo >> (bits - 1))) & mask);
      end else begin
        dst = (p - lo) + ((lo >> 1) | ((lo & 1) << (bits - 1)));
      end
      r[dst] = v[p];
    end
    return r;
  endfunction

  function automatic vec_t benes_model(input vec_t v, input benes_cfg_t c);
    vec_t r;
    r = switch_col(v, c, 0);
    r = switch_col(rotate_lanes(r, 3, 1'b0), c, 1);
    r = switch_col(rotate_lanes(r, 2, 1'b0), c, 2);
    r = switch_col(rotate_lanes(r, 2, 1'b1), c, 3);
    r = switch_col(rotate_lanes(r, 3, 1'b1), c, 4);
    return r;
  endfunction

  // Fills the write buffer with random vectors and may queue their expected results
  task automatic fill_vectors(input int n, input bit expect_out);
    logic [31:0] rnd;
    for (int b = 0; b < n; b++) begin
      for (int l = 0; l < lanes; l++) begin
        rnd          = $random(seed);
        wr_buf[b][l] = rnd[lane_w-1:0];
      end
      if (expect_out) begin
        exp_q.push_back(benes_model(wr_buf[b], cur_cfg));
      end
    end
  endtask

  task automatic axi_write_burst(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
                                 input int n, input axi_resp_e exp_resp);
    awid    = id;
    awaddr  = addr;
    awlen   = 8'(n - 1);
    awvalid = 1'b1;
    while (!awready) step();
    step();
    awvalid = 1'b0;
    for (int b = 0; b < n; b++) begin
      wdata  = wr_buf[b];
      wlast  = (b == n - 1);
      wvalid = 1'b1;
      while (!wready) step();
      step();
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    bready = 1'b1;
    while (!bvalid) step();
    check_resp("bresp", bresp, exp_resp);
    check_id("bid", bid, id);
    step();
    bready = 1'b0;
  endtask

  task automatic axi_read_burst(input logic [id_w-1:0] id, input int n, input bit stall);
    logic [31:0] rnd;
    int          beat;
    arid    = id;
    araddr  = '0;
    arlen   = 8'(n - 1);
    arvalid = 1'b1;
    while (!arready) step();
    step();
    arvalid = 1'b0;
    beat    = 0;
    while (beat < n) begin
      rnd    = $random(seed);
      rready = stall ? rnd[0] : 1'b1;
      if (rvalid && rready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Read returned a vector that was never written");
        end else begin
          check_vec("rdata", rdata, exp_q.pop_front());
        end
        check_id("rid", rid, id);
        check_resp("rresp", rresp, resp_okay);
        check_flag("rlast", rlast, beat == n - 1);
        beat++;
      end
      step();
    end
    rready = 1'b0;
  endtask

  task automatic write_config(input benes_cfg_t c);
    logic [lanes*lane_w-1:0] bits;
    bits        = '0;
    bits[19:0]  = c;
    wr_buf[0]   = bits;
    cur_cfg     = c;
    axi_write_burst(2'd0, 8'h40, 1, resp_okay);
  endtask

  task automatic identity_pass_through();
    write_config('0);
    fill_vectors(4, 1'b1);
    axi_write_burst(2'd1, 8'h00, 4, resp_okay);
    axi_read_burst(2'd2, 4, 1'b0);
  endtask

  task automatic random_permutation();
    logic [31:0] rnd;
    rnd = $random(seed);
    write_config(rnd[19:0]);
    fill_vectors(6, 1'b1);
    axi_write_burst(2'd3, 8'h00, 6, resp_okay);
    axi_read_burst(2'd1, 6, 1'b0);
  endtask

  // Twelve beats exceed what the queues and pipeline can absorb
  task automatic write_back_pressure();
    int unsigned wr_done;
    int unsigned rd_start;
    wr_done  = 0;
    rd_start = 0;
    fill_vectors(12, 1'b1);
    fork
      begin
        axi_write_burst(2'd2, 8'h00, 12, resp_okay);
        wr_done = cycles;
      end
      begin
        repeat (40) step();
        rd_start = cycles;
        axi_read_burst(2'd3, 12, 1'b0);
      end
    join
    if (wr_done <= rd_start) begin
      errors++;
      $display("The 12-beat write finished before any read drained results");
    end
  endtask

  task automatic read_with_stalls();
    fill_vectors(8, 1'b1);
    fork
      axi_write_burst(2'd0, 8'h00, 8, resp_okay);
      axi_read_burst(2'd2, 8, 1'b1);
    join
  endtask

  task automatic bad_region_write();
    fill_vectors(2, 1'b0);
    axi_write_burst(2'd1, 8'h80, 2, resp_slverr);
    fill_vectors(1, 1'b1);
    axi_write_burst(2'd2, 8'h00, 1, resp_okay);
    axi_read_burst(2'd3, 1, 1'b0);
  endtask

  task automatic read_before_write();
    fork
      axi_read_burst(2'd1, 1, 1'b0);
      begin
        repeat (20) begin
          check_flag("rvalid", rvalid, 1'b0);
          step();
        end
        fill_vectors(1, 1'b1);
        axi_write_burst(2'd0, 8'h00, 1, resp_okay);
      end
    join
  endtask

  initial begin
    seed          = 81;
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    assert_fails  = 0;
    cur_cfg       = '0;
    S_AXI_ACLK    = 1'b0;
    S_AXI_ARESETN = 1'b0;
    awid          = '0;
    awaddr        = '0;
    awlen         = '0;
    awburst       = 2'b01;
    awsize        = 3'd4;
    awvalid       = 1'b0;
    wdata         = '0;
    wlast         = 1'b0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    arid          = '0;
    araddr        = '0;
    arlen         = '0;
    arburst       = 2'b01;
    arsize        = 3'd4;
    arvalid       = 1'b0;
    rready        = 1'b0;
    repeat (16) @(posedge S_AXI_ACLK);
    #1;
    S_AXI_ARESETN = 1'b1;
    step();
    identity_pass_through();
    random_permutation();
    write_back_pressure();
    read_with_stalls();
    bad_region_write();
    read_before_write();
    assert_fails = i_dut.u_slave.u_slave_assert.fail_count
                 + i_dut.u_permuter.u_credit_assert.fail_count;
    $display("Checks run %0d, errors %0d, assertion failures %0d, cycles %0d",
             checks, errors, assert_fails, cycles);
    if (errors == 0 && assert_fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/axi_benes_assert.sv */
`default_nettype none

module axi_benes_assert #(
  parameter int fifo_depth = 4
) (
  input logic                             S_AXI_ACLK,
  input logic                             S_AXI_ARESETN,
  input logic                             awvalid,
  input logic                             awready,
  input logic                             wvalid,
  input logic                             wready,
  input logic                             bvalid,
  input logic                             bready,
  input logic                             arvalid,
  input logic                             arready,
  input logic                             rvalid,
  input logic                             rready,
  input logic [$clog2(fifo_depth+1)-1:0]  credit_cnt
);

  // Number of failed assertions in this instance
  int unsigned fail_count = 0;

  // Once raised, a valid holds until its ready
  aw_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    awvalid && !awready |=> awvalid)
    else begin
      $error("AWVALID dropped before AWREADY");
      fail_count++;
    end
  w_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    wvalid && !wready |=> wvalid)
    else begin
      $error("WVALID dropped before WREADY");
      fail_count++;
    end
  b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    bvalid && !bready |=> bvalid)
    else begin
      $error("BVALID dropped before BREADY");
      fail_count++;
    end
  ar_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    arvalid && !arready |=> arvalid)
    else begin
      $error("ARVALID dropped before ARREADY");
      fail_count++;
    end
  r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    rvalid && !rready |=> rvalid)
    else begin
      $error("RVALID dropped before RREADY");
      fail_count++;
    end

  // A push or pop with no credit left wraps the count above the bound
  credit_range: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    credit_cnt <= fifo_depth)
    else begin
      $error("credit counter out of range");
      fail_count++;
    end

endmodule

bind axi_burst_slave axi_benes_assert #(
  .fifo_depth (fifo_depth)
) u_slave_assert (
  .S_AXI_ACLK    (S_AXI_ACLK),
  .S_AXI_ARESETN (S_AXI_ARESETN),
  .awvalid       (awvalid),
  .awready       (awready),
  .wvalid        (wvalid),
  .wready        (wready),
  .bvalid        (bvalid),
  .bready        (bready),
  .arvalid       (arvalid),
  .arready       (arready),
  .rvalid        (rvalid),
  .rready        (rready),
  .credit_cnt    (in_cnt)
);

// Only the result credit counter of the permuter is watched
bind benes_permuter axi_benes_assert #(
  .fifo_depth (fifo_depth)
) u_credit_assert (
  .S_AXI_ACLK    (S_AXI_ACLK),
  .S_AXI_ARESETN (S_AXI_ARESETN),
  .awvalid       (1'b0),
  .awready       (1'b0),
  .wvalid        (1'b0),
  .wready        (1'b0),
  .bvalid        (1'b0),
  .bready        (1'b0),
  .arvalid       (1'b0),
  .arready       (1'b0),
  .rvalid        (1'b0),
  .rready        (1'b0),
  .credit_cnt    (res_cnt)
);

`default_nettype wire

/* verilog/axi_benes_top.sv */
`default_nettype none

module axi_benes_top
  import benes_pkg::*;
#(
  parameter int fifo_depth = 4,
  parameter int id_w       = 2,
  parameter int addr_w     = 8
) (
  input  logic              S_AXI_ACLK,
  input  logic              S_AXI_ARESETN,
  input  logic [id_w-1:0]   awid,
  input  logic [addr_w-1:0] awaddr,
  input  logic [7:0]        awlen,
  input  logic [1:0]        awburst,
  input  logic [2:0]        awsize,
  input  logic              awvalid,
  output logic              awready,
  input  vec_t              wdata,
  input  logic              wlast,
  input  logic              wvalid,
  output logic              wready,
  output logic [id_w-1:0]   bid,
  output axi_resp_e         bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [id_w-1:0]   arid,
  input  logic [addr_w-1:0] araddr,
  input  logic [7:0]        arlen,
  input  logic [1:0]        arburst,
  input  logic [2:0]        arsize,
  input  logic              arvalid,
  output logic              arready,
  output logic [id_w-1:0]   rid,
  output vec_t              rdata,
  output axi_resp_e         rresp,
  output logic              rlast,
  output logic              rvalid,
  input  logic              rready
);

  // Inbound hop
  logic       in_push;
  vec_t       in_data;
  logic       in_credit;
  vec_t       in_head;
  logic       in_empty;
  logic       in_pop;
  // Result hop
  logic       res_push;
  vec_t       res_data;
  logic       res_credit;
  vec_t       res_head;
  logic       res_empty;
  logic       res_pop;
  logic       cfg_load;
  benes_cfg_t cfg;

  axi_burst_slave #(
    .fifo_depth (fifo_depth),
    .id_w       (id_w),
    .addr_w     (addr_w)
  ) u_slave (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awid          (awid),
    .awaddr        (awaddr),
    .awlen         (awlen),
    .awburst       (awburst),
    .awsize        (awsize),
    .awvalid       (awvalid),
    .awready       (awready),
    .wdata         (wdata),
    .wlast         (wlast),
    .wvalid        (wvalid),
    .wready        (wready),
    .bid           (bid),
    .bresp         (bresp),
    .bvalid        (bvalid),
    .bready        (bready),
    .arid          (arid),
    .araddr        (araddr),
    .arlen         (arlen),
    .arburst       (arburst),
    .arsize        (arsize),
    .arvalid       (arvalid),
    .arready       (arready),
    .rid           (rid),
    .rdata         (rdata),
    .rresp         (rresp),
    .rlast         (rlast),
    .rvalid        (rvalid),
    .rready        (rready),
    .in_push       (in_push),
    .in_data       (in_data),
    .in_credit     (in_credit),
    .res_head      (res_head),
    .res_empty     (res_empty),
    .res_pop       (res_pop),
    .cfg_load      (cfg_load),
    .cfg           (cfg)
  );

  vector_fifo #(
    .fifo_depth (fifo_depth)
  ) u_in_q (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .push          (in_push),
    .push_data     (in_data),
    .pop           (in_pop),
    .head          (in_head),
    .empty         (in_empty),
    .credit        (in_credit)
  );

  benes_permuter #(
    .fifo_depth (fifo_depth)
  ) u_permuter (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .cfg_load      (cfg_load),
    .cfg           (cfg),
    .in_head       (in_head),
    .in_empty      (in_empty),
    .res_credit    (res_credit),
    .in_pop        (in_pop),
    .res_push      (res_push),
    .res_data      (res_data)
  );

  vector_fifo #(
    .fifo_depth (fifo_depth)
  ) u_res_q (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .push          (res_push),
    .push_data     (res_data),
    .pop           (res_pop),
    .head          (res_head),
    .empty         (res_empty),
    .credit        (res_credit)
  );

endmodule

`default_nettype wire

/* verilog/axi_burst_slave.sv */
`default_nettype none

module axi_burst_slave
  import benes_pkg::*;
#(
  parameter int fifo_depth = 4,
  parameter int id_w       = 2,
  parameter int addr_w     = 8
) (
  input  logic              S_AXI_ACLK,
  input  logic              S_AXI_ARESETN,
  input  logic [id_w-1:0]   awid,
  input  logic [addr_w-1:0] awaddr,
  input  logic [7:0]        awlen,
  input  logic [1:0]        awburst,
  input  logic [2:0]        awsize,
  input  logic              awvalid,
  output logic              awready,
  input  vec_t              wdata,
  input  logic              wlast,
  input  logic              wvalid,
  output logic              wready,
  output logic [id_w-1:0]   bid,
  output axi_resp_e         bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [id_w-1:0]   arid,
  input  logic [addr_w-1:0] araddr,
  input  logic [7:0]        arlen,
  input  logic [1:0]        arburst,
  input  logic [2:0]        arsize,
  input  logic              arvalid,
  output logic              arready,
  output logic [id_w-1:0]   rid,
  output vec_t              rdata,
  output axi_resp_e         rresp,
  output logic              rlast,
  output logic              rvalid,
  input  logic              rready,
  output logic              in_push,
  output vec_t              in_data,
  input  logic              in_credit,
  input  vec_t              res_head,
  input  logic              res_empty,
  output logic              res_pop,
  output logic              cfg_load,
  output benes_cfg_t        cfg
);

  localparam int cnt_w = $clog2(fifo_depth + 1);

  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_resp
  } wr_state_e;

  wr_state_e                wr_state;
  aw_req_t                  aw_q;
  benes_op_e                aw_op;
  logic                     aw_fire;
  logic                     w_fire;
  logic [cnt_w-1:0]         in_cnt;
  logic [lanes*lane_w-1:0]  wdata_bits;
  logic                     rd_active;
  logic [id_w-1:0]          ar_id;
  logic [7:0]               ar_len;
  logic [7:0]               beat_cnt;

  // Data is a stream, so awlen, awburst, awsize, araddr, arburst and arsize
  // have no effect here. WLAST and the read beat count close the bursts.

  always_comb begin
    case (awaddr[7:6])
      2'd0:    aw_op = op_data;
      2'd1:    aw_op = op_cfg;
      default: aw_op = op_bad;
    endcase
  end

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;

  // Data beats wait for an inbound credit, other regions always accept
  assign wready = (wr_state == wr_data) && ((aw_q.op != op_data) || (in_cnt != '0));

  assign in_push = w_fire && (aw_q.op == op_data);
  assign in_data = wdata;

  // Configuration is taken from the last beat of the burst
  assign wdata_bits = wdata;
  assign cfg_load   = w_fire && wlast && (aw_q.op == op_cfg);
  assign cfg        = wdata_bits[$bits(benes_cfg_t)-1:0];

  assign bid = aw_q.id[id_w-1:0];

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_state <= wr_idle;
      awready  <= 1'b0;
      bvalid   <= 1'b0;
    end else begin
      case (wr_state)
        wr_idle: begin
          if (aw_fire) begin
            awready  <= 1'b0;
            wr_state <= wr_data;
          end else if (awvalid) begin
            awready <= 1'b1;
          end
        end
        wr_data: begin
          if (w_fire && wlast) begin
            bvalid   <= 1'b1;
            wr_state <= wr_resp;
          end
        end
        wr_resp: begin
          if (bready) begin
            bvalid   <= 1'b0;
            wr_state <= wr_idle;
          end
        end
        default: wr_state <= wr_idle;
      endcase
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (aw_fire) begin
      aw_q.id <= aw_id_w'(awid);
      aw_q.op <= aw_op;
    end
    if (w_fire && wlast) begin
      bresp <= (aw_q.op == op_bad) ? resp_slverr : resp_okay;
    end
  end

  // Inbound credits, spent on push and returned as the queue drains
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      in_cnt <= cnt_w'(fifo_depth);
    end else if (in_push && !in_credit) begin
      in_cnt <= in_cnt - 1'b1;
    end else if (!in_push && in_credit) begin
      in_cnt <= in_cnt + 1'b1;
    end
  end

  // Read side
  assign rvalid  = rd_active && !res_empty;
  assign rdata   = res_head;
  assign rresp   = resp_okay;
  assign rid     = ar_id;
  assign rlast   = rd_active && (beat_cnt == ar_len);
  assign res_pop = rvalid && rready;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      arready   <= 1'b0;
      rd_active <= 1'b0;
    end else begin
      if (arvalid && arready) begin
        arready   <= 1'b0;
        rd_active <= 1'b1;
      end else if (!rd_active && arvalid) begin
        arready <= 1'b1;
      end
      if (res_pop && rlast) begin
        rd_active <= 1'b0;
      end
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (arvalid && arready) begin
      ar_id    <= arid;
      ar_len   <= arlen;
      beat_cnt <= '0;
    end else if (res_pop) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/benes_permuter.sv */
`default_nettype none

module benes_permuter
  import benes_pkg::*;
#(
  parameter int fifo_depth = 4
) (
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  input  logic       cfg_load,
  input  benes_cfg_t cfg,
  input  vec_t       in_head,
  input  logic       in_empty,
  input  logic       res_credit,
  output logic       in_pop,
  output logic       res_push,
  output vec_t       res_data
);

  localparam int cnt_w = $clog2(fifo_depth + 1);

  benes_cfg_t       cfg_q;
  logic [cnt_w-1:0] res_cnt;
  vec_t             front;
  vec_t             back;
  logic             mid_valid;
  vec_t             mid_data;
  logic [7:0]       mid_cfg;

  // One column of four 2x2 switches, a set bit swaps the pair
  function automatic vec_t switch_stage(input vec_t v, input logic [3:0] sw);
    vec_t r;
    r = v;
    for (int k = 0; k < lanes / 2; k++) begin
      if (sw[k]) begin
        r[2*k]   = v[2*k+1];
        r[2*k+1] = v[2*k];
      end
    end
    return r;
  endfunction

  // Inverse perfect shuffle within groups of n lanes
  // even lanes go to the lower half of the group, odd lanes to the upper
  function automatic vec_t unshuffle(input vec_t v, input int n);
    vec_t r;
    int   base;
    int   j;
    for (int i = 0; i < lanes; i++) begin
      base = (i / n) * n;
      j    = i % n;
      r[base + j/2 + (j%2)*(n/2)] = v[i];
    end
    return r;
  endfunction

  // Perfect shuffle within groups of n lanes, interleaves the two halves
  function automatic vec_t shuffle(input vec_t v, input int n);
    vec_t r;
    int   base;
    int   j;
    for (int i = 0; i < lanes; i++) begin
      base = (i / n) * n;
      j    = i % n;
      r[i] = v[base + j/2 + (j%2)*(n/2)];
    end
    return r;
  endfunction

  // Stages 0 to 2
  always_comb begin
    front = switch_stage(in_head, cfg_q[3:0]);
    front = switch_stage(unshuffle(front, lanes), cfg_q[7:4]);
    front = switch_stage(unshuffle(front, lanes / 2), cfg_q[11:8]);
  end

  // Stages 3 and 4 with the settings captured at pop time
  always_comb begin
    back = switch_stage(shuffle(mid_data, lanes / 2), mid_cfg[3:0]);
    back = switch_stage(shuffle(back, lanes), mid_cfg[7:4]);
  end

  assign in_pop = !in_empty && (res_cnt != '0);

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      cfg_q     <= '0;
      res_cnt   <= cnt_w'(fifo_depth);
      mid_valid <= 1'b0;
      res_push  <= 1'b0;
    end else begin
      if (cfg_load) begin
        cfg_q <= cfg;
      end
      if (in_pop && !res_credit) begin
        res_cnt <= res_cnt - 1'b1;
      end else if (!in_pop && res_credit) begin
        res_cnt <= res_cnt + 1'b1;
      end
      mid_valid <= in_pop;
      res_push  <= mid_valid;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    mid_data <= front;
    mid_cfg  <= cfg_q[19:12];
    res_data <= back;
  end

endmodule

`default_nettype wire

/* verilog/vector_fifo.sv */
`default_nettype none

module vector_fifo
  import benes_pkg::*;
#(
  parameter int fifo_depth = 4
) (
  input  logic S_AXI_ACLK,
  input  logic S_AXI_ARESETN,
  input  logic push,
  input  vec_t push_data,
  input  logic pop,
  output vec_t head,
  output logic empty,
  output logic credit
);

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  vec_t             mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  // Pointer advance with wrap, depth need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(fifo_depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // No full check, the sender only pushes while it holds a credit
  always_ff @(posedge S_AXI_ACLK) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back per entry leaving
      credit <= pop;
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (count == '0);

endmodule

`default_nettype wire

/* verilog/benes_pkg.sv */
`default_nettype none

package benes_pkg;

  // Vector geometry
  localparam int lanes  = 8;
  localparam int lane_w = 16;

  // Widest AXI ID the latched write request can carry
  localparam int aw_id_w = 8;

  typedef logic [lane_w-1:0] lane_t;

  // Lane 0 sits in the low bits
  typedef lane_t [lanes-1:0] vec_t;

  // Five stages of four switches, bit index is stage * 4 + switch
  typedef logic [19:0] benes_cfg_t;

  typedef enum logic [1:0] {
    resp_okay   = 2'd0,
    resp_slverr = 2'd2
  } axi_resp_e;

  // Write region, decoded from address bits 7:6
  typedef enum logic [1:0] {
    op_data = 2'd0,
    op_cfg  = 2'd1,
    op_bad  = 2'd2
  } benes_op_e;

  // Write request held for the length of a burst
  typedef struct packed {
    logic [aw_id_w-1:0] id;
    benes_op_e          op;
  } aw_req_t;

endpackage

`default_nettype wire
